/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_cam_hdmi_bridge
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/cam_hdmi_bridge.sv */
`timescale 1ns/1ps

module cam_hdmi_bridge (
    input  logic                 pix_clk,
    input  logic                 resetn,
    input  logic                 cam_pclk,
    input  logic                 cam_resetn,
    input  logic                 cam_line_valid,
    input  logic                 cam_y_valid,
    input  line_buf_pkg::pixel_t cam_y,
    output line_buf_pkg::pixel_t pix_y,
    output logic                 pix_de,
    output logic                 hsync,
    output logic                 vsync
);
    import video_timing_pkg::*;
    import line_buf_pkg::*;

    h_count_t   h_count;
    logic       active;
    logic       line_start;
    logic       vsync_fall;
    logic       wr_en;
    buf_idx_t   wr_buf;
    line_addr_t wr_addr;
    logic       desc_send;
    buf_idx_t   desc_buf_cam;
    logic       desc_recv;
    buf_idx_t   desc_buf_pix;
    buf_idx_t   cur_buf;
    logic       rd_enable;
    logic       rel_send;
    buf_mask_t  rel_mask_pix;
    logic       rel_recv;
    buf_mask_t  rel_mask_cam;

    video_timing_gen u_timing (
        .pix_clk    (pix_clk),
        .resetn     (resetn),
        .h_count    (h_count),
        .active     (active),
        .line_start (line_start),
        .vsync_fall (vsync_fall),
        .pix_de     (pix_de),
        .hsync      (hsync),
        .vsync      (vsync)
    );

    // ----------------------------------------------------------------------
    // camera domain
    // ----------------------------------------------------------------------
    line_capture u_capture (
        .cam_pclk       (cam_pclk),
        .cam_resetn     (cam_resetn),
        .cam_line_valid (cam_line_valid),
        .cam_y_valid    (cam_y_valid),
        .rel_recv       (rel_recv),
        .rel_mask_in    (rel_mask_cam),
        .wr_en          (wr_en),
        .wr_buf         (wr_buf),
        .wr_addr        (wr_addr),
        .desc_send      (desc_send),
        .desc_buf       (desc_buf_cam)
    );

    line_buffer_bank u_bank (
        .cam_pclk  (cam_pclk),
        .wr_en     (wr_en),
        .wr_buf    (wr_buf),
        .wr_addr   (wr_addr),
        .wr_data   (cam_y),
        .pix_clk   (pix_clk),
        .resetn    (resetn),
        .rd_addr   (h_count[9:0]),
        .rd_buf    (cur_buf),
        .rd_enable (rd_enable),
        .pix_y     (pix_y)
    );

    // ----------------------------------------------------------------------
    // crossings, finished lines one way and releases back
    // ----------------------------------------------------------------------
    toggle_cdc #(.payload_t(buf_idx_t)) u_desc_cdc (
        .src_clk    (cam_pclk),
        .src_resetn (cam_resetn),
        .send       (desc_send),
        .data       (desc_buf_cam),
        .dst_clk    (pix_clk),
        .dst_resetn (resetn),
        .recv       (desc_recv),
        .recv_data  (desc_buf_pix)
    );

    toggle_cdc #(.payload_t(buf_mask_t)) u_rel_cdc (
        .src_clk    (pix_clk),
        .src_resetn (resetn),
        .send       (rel_send),
        .data       (rel_mask_pix),
        .dst_clk    (cam_pclk),
        .dst_resetn (cam_resetn),
        .recv       (rel_recv),
        .recv_data  (rel_mask_cam)
    );

    line_scheduler u_sched (
        .pix_clk    (pix_clk),
        .resetn     (resetn),
        .desc_recv  (desc_recv),
        .desc_buf   (desc_buf_pix),
        .line_start (line_start),
        .vsync_fall (vsync_fall),
        .active     (active),
        .cur_buf    (cur_buf),
        .rd_enable  (rd_enable),
        .rel_send   (rel_send),
        .rel_mask   (rel_mask_pix)
    );

endmodule

/* hw/line_buf_pkg.sv */
`include "bridge_consts.svh"

package line_buf_pkg;

    // index of one line memory
    typedef logic [$clog2(`NUM_BUFS)-1:0] buf_idx_t;

    // one bit per line memory, for the free map and for releases
    typedef logic [`NUM_BUFS-1:0] buf_mask_t;

    // 8-bit luma sample
    typedef logic [7:0] pixel_t;

    // sample address within a line
    typedef logic [$clog2(`H_ACTIVE)-1:0] line_addr_t;

endpackage

/* hw/line_buffer_bank.sv */
`timescale 1ns/1ps
`include "bridge_consts.svh"

module line_buffer_bank (
    input  logic                     cam_pclk,
    input  logic                     wr_en,
    input  line_buf_pkg::buf_idx_t   wr_buf,
    input  line_buf_pkg::line_addr_t wr_addr,
    input  line_buf_pkg::pixel_t     wr_data,
    input  logic                     pix_clk,
    input  logic                     resetn,
    input  line_buf_pkg::line_addr_t rd_addr,
    input  line_buf_pkg::buf_idx_t   rd_buf,
    input  logic                     rd_enable,
    output line_buf_pkg::pixel_t     pix_y
);
    import line_buf_pkg::*;

    pixel_t rd_word [`NUM_BUFS];

    // one dual-clock memory per buffer, write decoded by index
    for (genvar b = 0; b < `NUM_BUFS; b++) begin : g_line
        pixel_t mem [`H_ACTIVE];

        always_ff @(posedge cam_pclk) begin
            if (wr_en && (wr_buf == buf_idx_t'(b))) begin
                mem[wr_addr] <= wr_data;
            end
        end

        assign rd_word[b] = mem[rd_addr];
    end

    // read mux, black outside active video or with nothing held
    always_ff @(posedge pix_clk or negedge resetn) begin
        if (!resetn) begin
            pix_y <= '0;
        end else if (rd_enable) begin
            pix_y <= rd_word[rd_buf];
        end else begin
            pix_y <= '0;
        end
    end

endmodule

/* hw/line_capture.sv */
`timescale 1ns/1ps
`include "bridge_consts.svh"

module line_capture (
    input  logic                     cam_pclk,
    input  logic                     cam_resetn,
    input  logic                     cam_line_valid,
    input  logic                     cam_y_valid,
    input  logic                     rel_recv,
    input  line_buf_pkg::buf_mask_t  rel_mask_in,
    output logic                     wr_en,
    output line_buf_pkg::buf_idx_t   wr_buf,
    output line_buf_pkg::line_addr_t wr_addr,
    output logic                     desc_send,
    output line_buf_pkg::buf_idx_t   desc_buf
);
    import line_buf_pkg::*;

    buf_mask_t free_map;
    buf_idx_t  line_buf;
    logic      line_drop;
    logic      line_valid_d;
    logic      line_rise;
    logic      line_fall;
    buf_idx_t  alloc_idx;
    logic      alloc_ok;
    logic      line_ok;
    buf_mask_t rel_bits;
    buf_mask_t take_bit;

    assign line_rise = cam_line_valid && !line_valid_d;
    assign line_fall = !cam_line_valid && line_valid_d;

    // ----------------------------------------------------------------------
    // buffer allocation
    // ----------------------------------------------------------------------
    // lowest free index wins
    always_comb begin
        alloc_ok  = 1'b0;
        alloc_idx = '0;
        for (int i = `NUM_BUFS - 1; i >= 0; i--) begin
            if (free_map[i]) begin
                alloc_ok  = 1'b1;
                alloc_idx = buf_idx_t'(i);
            end
        end
    end

    assign rel_bits = rel_recv ? rel_mask_in : '0;
    assign take_bit = (line_rise && alloc_ok) ? (buf_mask_t'(1'b1) << alloc_idx) : '0;

    // ----------------------------------------------------------------------
    // write side
    // ----------------------------------------------------------------------
    // a sample may come with the first line_valid cycle, so bypass the
    // allocation result on that cycle
    assign line_ok = line_rise ? alloc_ok : !line_drop;
    assign wr_buf  = line_rise ? alloc_idx : line_buf;
    assign wr_en   = cam_line_valid && cam_y_valid && line_ok && (wr_addr < `H_ACTIVE);

    // descriptor goes out on the falling edge of line_valid
    assign desc_send = line_fall && !line_drop;
    assign desc_buf  = line_buf;

    always_ff @(posedge cam_pclk or negedge cam_resetn) begin
        if (!cam_resetn) begin
            free_map     <= '1;
            line_buf     <= '0;
            line_drop    <= 1'b0;
            line_valid_d <= 1'b0;
            wr_addr      <= '0;
        end else begin
            line_valid_d <= cam_line_valid;
            free_map     <= (free_map | rel_bits) & ~take_bit;

            if (line_rise) begin
                line_drop <= !alloc_ok;
                if (alloc_ok) begin
                    line_buf <= alloc_idx;
                end
            end

            // address stays parked at 0 between lines, saturates at the top
            if (!cam_line_valid) begin
                wr_addr <= '0;
            end else if (cam_y_valid && (wr_addr != '1)) begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

endmodule

/* hw/line_scheduler.sv */
`timescale 1ns/1ps
`include "bridge_consts.svh"

module line_scheduler (
    input  logic                    pix_clk,
    input  logic                    resetn,
    input  logic                    desc_recv,
    input  line_buf_pkg::buf_idx_t  desc_buf,
    input  logic                    line_start,
    input  logic                    vsync_fall,
    input  logic                    active,
    output line_buf_pkg::buf_idx_t  cur_buf,
    output logic                    rd_enable,
    output logic                    rel_send,
    output line_buf_pkg::buf_mask_t rel_mask
);
    import line_buf_pkg::*;

    localparam int PTR_W = $clog2(`DESC_DEPTH);
    // spacing between release transfers, in pixel clocks
    localparam logic [2:0] REL_GAP = 3'd7;

    buf_idx_t         fifo [`DESC_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             repeat_phase;
    buf_idx_t         cur_q;
    logic             cur_valid;
    buf_mask_t        rel_accum;
    logic [2:0]       rel_hold;
    logic             push;
    logic             overflow;
    logic             fetch;
    logic             send_now;
    buf_mask_t        rel_new;

    // ----------------------------------------------------------------------
    // descriptor FIFO and line doubling
    // ----------------------------------------------------------------------
    assign push     = desc_recv && (count != `DESC_DEPTH);
    assign overflow = desc_recv && (count == `DESC_DEPTH);
    // fetch only on the first of each pair of active lines
    assign fetch    = line_start && !repeat_phase && (count != '0);

    // new head is used on the very cycle it is fetched, pixel 0 included
    assign cur_buf   = fetch ? fifo[rd_ptr] : cur_q;
    assign rd_enable = active && (cur_valid || fetch);

    // buffers given up this cycle
    always_comb begin
        rel_new = '0;
        if (overflow) begin
            rel_new = rel_new | (buf_mask_t'(1'b1) << desc_buf);
        end
        if (fetch && cur_valid) begin
            rel_new = rel_new | (buf_mask_t'(1'b1) << cur_q);
        end
    end

    assign send_now = (rel_hold == '0) && (rel_accum != '0);

    always_ff @(posedge pix_clk or negedge resetn) begin
        if (!resetn) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            repeat_phase <= 1'b0;
            cur_q        <= '0;
            cur_valid    <= 1'b0;
            rel_accum    <= '0;
            rel_hold     <= '0;
            rel_send     <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fetch) begin
                rd_ptr    <= rd_ptr + 1'b1;
                cur_q     <= fifo[rd_ptr];
                cur_valid <= 1'b1;
            end

            case ({push, fetch})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            if (vsync_fall) begin
                repeat_phase <= 1'b0;
            end else if (line_start) begin
                repeat_phase <= ~repeat_phase;
            end

            // ------------------------------------------------------------------
            // release accumulation
            // ------------------------------------------------------------------
            rel_send <= send_now;
            if (send_now) begin
                rel_accum <= rel_new;
                rel_hold  <= REL_GAP;
            end else begin
                rel_accum <= rel_accum | rel_new;
                if (rel_hold != '0) begin
                    rel_hold <= rel_hold - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge pix_clk) begin
        if (push) begin
            fifo[wr_ptr] <= desc_buf;
        end
        if (send_now) begin
            rel_mask <= rel_accum;
        end
    end

endmodule

/* hw/toggle_cdc.sv */
`timescale 1ns/1ps

module toggle_cdc #(
    parameter type payload_t = logic
) (
    input  logic     src_clk,
    input  logic     src_resetn,
    input  logic     send,
    input  payload_t data,
    input  logic     dst_clk,
    input  logic     dst_resetn,
    output logic     recv,
    output payload_t recv_data
);

    logic       src_toggle;
    logic       src_pending;
    payload_t   src_data;
    logic [2:0] dst_sync;
    payload_t   dst_data_s1;

    // ----------------------------------------------------------------------
    // source side
    // ----------------------------------------------------------------------
    // toggle flips one cycle after the payload is captured
    always_ff @(posedge src_clk or negedge src_resetn) begin
        if (!src_resetn) begin
            src_toggle  <= 1'b0;
            src_pending <= 1'b0;
        end else begin
            src_pending <= send;
            if (src_pending) begin
                src_toggle <= ~src_toggle;
            end
        end
    end

    always_ff @(posedge src_clk) begin
        if (send) begin
            src_data <= data;
        end
    end

    // ----------------------------------------------------------------------
    // destination side
    // ----------------------------------------------------------------------
    always_ff @(posedge dst_clk or negedge dst_resetn) begin
        if (!dst_resetn) begin
            dst_sync <= '0;
        end else begin
            dst_sync <= {dst_sync[1:0], src_toggle};
        end
    end

    // payload has been stable for a while by the time the toggle shows up
    always_ff @(posedge dst_clk) begin
        dst_data_s1 <= src_data;
        recv_data   <= dst_data_s1;
    end

    assign recv = dst_sync[2] ^ dst_sync[1];

endmodule

/* hw/video_timing_gen.sv */
`timescale 1ns/1ps
`include "bridge_consts.svh"

module video_timing_gen (
    input  logic                       pix_clk,
    input  logic                       resetn,
    output video_timing_pkg::h_count_t h_count,
    output logic                       active,
    output logic                       line_start,
    output logic                       vsync_fall,
    output logic                       pix_de,
    output logic                       hsync,
    output logic                       vsync
);
    import video_timing_pkg::*;

    v_count_t v_count;
    logic     h_last;
    logic     in_hsync;
    logic     in_vsync;

    assign h_last = (h_count == `H_TOTAL - 1);

    always_ff @(posedge pix_clk or negedge resetn) begin
        if (!resetn) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_last) begin
            h_count <= '0;
            if (v_count == `V_TOTAL - 1) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 1'b1;
            end
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // decode of the current count
    // ----------------------------------------------------------------------
    assign active     = (h_count < `H_ACTIVE) && (v_count < `V_ACTIVE);
    assign line_start = (h_count == '0) && (v_count < `V_ACTIVE);
    // first cycle of the vsync pulse
    assign vsync_fall = (h_count == '0) && (v_count == `V_ACTIVE + `V_FP);

    assign in_hsync = (h_count >= `H_ACTIVE + `H_FP) &&
                      (h_count <  `H_ACTIVE + `H_FP + `H_SYNC);
    assign in_vsync = (v_count >= `V_ACTIVE + `V_FP) &&
                      (v_count <  `V_ACTIVE + `V_FP + `V_SYNC);

    // one cycle late, same as the registered pixel out of the bank
    always_ff @(posedge pix_clk or negedge resetn) begin
        if (!resetn) begin
            pix_de <= 1'b0;
            hsync  <= 1'b1;
            vsync  <= 1'b1;
        end else begin
            pix_de <= active;
            hsync  <= ~in_hsync;
            vsync  <= ~in_vsync;
        end
    end

endmodule

/* hw/video_timing_pkg.sv */
package video_timing_pkg;

    // pixel position within a line, wraps at 858
    typedef logic [10:0] h_count_t;

    // line position within a frame, wraps at 525
    typedef logic [9:0] v_count_t;

endpackage

/* include/bridge_consts.svh */
`ifndef BRIDGE_CONSTS_SVH
`define BRIDGE_CONSTS_SVH

// ----------------------------------------------------------------------
// 720x480p horizontal timing, in pixels
// ----------------------------------------------------------------------
`define H_ACTIVE 720
`define H_FP     16
`define H_SYNC   62
`define H_BP     60
`define H_TOTAL  (`H_ACTIVE + `H_FP + `H_SYNC + `H_BP)

// ----------------------------------------------------------------------
// vertical timing, in lines
// ----------------------------------------------------------------------
`define V_ACTIVE 480
`define V_FP     9
`define V_SYNC   6
`define V_BP     30
`define V_TOTAL  (`V_ACTIVE + `V_FP + `V_SYNC + `V_BP)

// ----------------------------------------------------------------------
// line storage
// ----------------------------------------------------------------------
// number of line memories shared by camera and display
`define NUM_BUFS   8

// entries in the pixel-side descriptor FIFO
`define DESC_DEPTH 16

`endif

/* project.f */
+incdir+include
hw/video_timing_pkg.sv
hw/line_buf_pkg.sv
hw/video_timing_gen.sv
hw/toggle_cdc.sv
hw/line_capture.sv
hw/line_buffer_bank.sv
hw/line_scheduler.sv
hw/cam_hdmi_bridge.sv
sim/cam_line_source.sv
sim/tb_cam_hdmi_bridge.sv

/* sim/cam_line_source.sv */
`timescale 1ns/1ps

module cam_line_source #(
    parameter int BURST_LINES = 12,
    parameter int BURST_LEN   = 32
) (
    input  logic       cam_pclk,
    input  logic       cam_resetn,
    input  logic       burst_req,
    output logic       cam_line_valid,
    output logic       cam_y_valid,
    output logic [7:0] cam_y,
    output logic       line_done,
    output logic [7:0] done_tag,
    output logic       done_short
);

    logic [31:0] lfsr;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    // sample x of a line carries tag + x
    task automatic send_line(input logic [7:0] tag, input int len, input logic short_line);
        for (int x = 0; x < len; x++) begin
            @(posedge cam_pclk);
            cam_line_valid <= 1'b1;
            cam_y_valid    <= 1'b1;
            cam_y          <= tag + 8'(x);
        end
        @(posedge cam_pclk);
        cam_line_valid <= 1'b0;
        cam_y_valid    <= 1'b0;
        cam_y          <= 8'h00;
        line_done      <= 1'b1;
        done_tag       <= tag;
        done_short     <= short_line;
        @(posedge cam_pclk);
        line_done <= 1'b0;
    endtask

    initial begin
        int   gap;
        int   tag;
        int   extra;
        logic burst_taken;
        lfsr           = 32'h3265_0e79;
        burst_taken    = 1'b0;
        cam_line_valid = 1'b0;
        cam_y_valid    = 1'b0;
        cam_y          = 8'h00;
        line_done      = 1'b0;
        done_tag       = 8'h00;
        done_short     = 1'b0;
        wait (cam_resetn);
        forever begin
            if (burst_req && !burst_taken) begin
                // short lines back to back
                for (int n = 0; n < BURST_LINES; n++) begin
                    take_bits(8, tag);
                    send_line(8'(tag), BURST_LEN, 1'b1);
                end
                burst_taken = 1'b1;
            end else begin
                take_bits(11, gap);
                repeat (16 + gap) @(posedge cam_pclk);
                take_bits(8, tag);
                // a few samples past the line end now and then
                take_bits(2, extra);
                send_line(8'(tag), 720 + extra, 1'b0);
            end
        end
    end

endmodule

/* sim/tb_cam_hdmi_bridge.sv */
`timescale 1ns/1ps
`include "bridge_consts.svh"

module tb_cam_hdmi_bridge;

    localparam int T_TIMING    = 0;
    localparam int T_BLANK     = 1;
    localparam int T_LINE      = 2;
    localparam int T_ORDER     = 3;
    localparam int T_EXHAUST   = 4;
    localparam int N_TESTS     = 5;
    localparam int BURST_LINES = 12;
    // four frames plus margin for reset
    localparam int TIMEOUT_CYCLES = 4 * `H_TOTAL * `V_TOTAL + 4096;

    logic       pix_clk;
    logic       resetn;
    logic       cam_pclk;
    logic       cam_resetn;
    logic       cam_line_valid;
    logic       cam_y_valid;
    logic [7:0] cam_y;
    logic [7:0] pix_y;
    logic       pix_de;
    logic       hsync;
    logic       vsync;
    logic       burst_req;
    logic       line_done;
    logic [7:0] done_tag;
    logic       done_short;

    string test_name [N_TESTS] = '{"timing", "blank_start", "line_integrity",
                                   "order_doubling", "exhaustion"};
    int    errs [N_TESTS];
    int    cycles;

    // scoreboard holds one entry per finished camera line
    logic [7:0] sb_tag [$];
    int         sb_seq [$];
    logic       sb_short [$];
    int         seq_count;
    int         short_count;
    int         last_short_seq;
    logic       first_done;

    // display side
    logic [7:0] line_pix [`H_ACTIVE];
    int         de_len;
    int         hs_len;
    int         vs_len;
    int         since_de;
    int         active_lines;
    int         vs_falls;
    int         vs_rises;
    logic       de_d;
    logic       hs_d;
    logic       vs_d;
    logic       de_fell;
    logic       shown_any;
    logic       resumed;
    logic [7:0] cur_tag;
    int         cur_run;
    int         cur_seq;

    always #50 pix_clk = ~pix_clk;
    always #37 cam_pclk = ~cam_pclk;

    cam_hdmi_bridge i_cam_hdmi_bridge (
        .pix_clk        (pix_clk),
        .resetn         (resetn),
        .cam_pclk       (cam_pclk),
        .cam_resetn     (cam_resetn),
        .cam_line_valid (cam_line_valid),
        .cam_y_valid    (cam_y_valid),
        .cam_y          (cam_y),
        .pix_y          (pix_y),
        .pix_de         (pix_de),
        .hsync          (hsync),
        .vsync          (vsync)
    );

    cam_line_source #(.BURST_LINES(BURST_LINES)) u_cam_src (
        .cam_pclk       (cam_pclk),
        .cam_resetn     (cam_resetn),
        .burst_req      (burst_req),
        .cam_line_valid (cam_line_valid),
        .cam_y_valid    (cam_y_valid),
        .cam_y          (cam_y),
        .line_done      (line_done),
        .done_tag       (done_tag),
        .done_short     (done_short)
    );

    task automatic flag_mismatch(input int t, input int exp_v, input int act_v);
        $display("CHECK FAILED %s expected %0d actual %0d", test_name[t], exp_v, act_v);
        errs[t]++;
    endtask

    task automatic note_problem(input int t, input string what);
        $display("%s: %s", test_name[t], what);
        errs[t]++;
    endtask

    task automatic print_result(input int t);
        $display("test %s %s, %0d check failures", test_name[t],
                 (errs[t] == 0) ? "ok" : "FAILED", errs[t]);
    endtask

    // --------------------------------------------------------------------
    // one finished active line against the scoreboard
    // --------------------------------------------------------------------
    task automatic check_line();
        logic       all_zero;
        logic       found;
        logic       was_short;
        logic [7:0] tag;
        logic [7:0] want;
        int         bad_x;
        all_zero  = 1'b1;
        found     = 1'b0;
        was_short = 1'b0;
        tag       = line_pix[0];
        want      = 8'h00;
        bad_x     = -1;
        for (int x = 0; x < `H_ACTIVE; x++) begin
            if (line_pix[x] != 8'h00) begin
                all_zero = 1'b0;
            end
            if (bad_x < 0 && line_pix[x] != tag + 8'(x)) begin
                bad_x = x;
                want  = tag + 8'(x);
            end
        end
        // nothing fetched yet
        if (all_zero && !shown_any) begin
            return;
        end
        assert (bad_x < 0) else flag_mismatch(T_LINE, int'(want), int'(line_pix[bad_x]));
        if (shown_any && tag == cur_tag) begin
            cur_run++;
            return;
        end
        // older entries were dropped or released
        while (!found && sb_tag.size() > 0) begin
            if (sb_tag[0] == tag) begin
                found     = 1'b1;
                cur_seq   = sb_seq[0];
                was_short = sb_short[0];
            end
            void'(sb_tag.pop_front());
            void'(sb_seq.pop_front());
            void'(sb_short.pop_front());
        end
        assert (found) else note_problem(T_ORDER, "shown line is not ahead in send order");
        if (shown_any) begin
            assert (cur_run >= 2) else flag_mismatch(T_ORDER, 2, cur_run);
        end
        assert (!was_short) else note_problem(T_EXHAUST, "a short burst line was shown");
        if (found && short_count == BURST_LINES && cur_seq > last_short_seq) begin
            resumed = 1'b1;
        end
        shown_any = 1'b1;
        cur_tag   = tag;
        cur_run   = 1;
    endtask

    always @(negedge cam_pclk) begin
        if (line_done) begin
            seq_count++;
            sb_tag.push_back(done_tag);
            sb_seq.push_back(seq_count);
            sb_short.push_back(done_short);
            first_done = 1'b1;
            if (done_short) begin
                short_count++;
                last_short_seq = seq_count;
            end
        end
    end

    // DUT outputs sampled on the falling edge
    always @(negedge pix_clk) begin
        if (resetn) begin
            assert (pix_de || pix_y == 8'h00) else flag_mismatch(T_BLANK, 0, int'(pix_y));
            if (!first_done) begin
                assert (pix_y == 8'h00) else flag_mismatch(T_BLANK, 0, int'(pix_y));
            end
            if (pix_de) begin
                if (de_len < `H_ACTIVE) begin
                    line_pix[de_len] = pix_y;
                end
                de_len++;
            end
            if (de_d && !pix_de) begin
                assert (de_len == `H_ACTIVE) else flag_mismatch(T_TIMING, `H_ACTIVE, de_len);
                check_line();
                active_lines++;
                de_len   = 0;
                since_de = 0;
                de_fell  = 1'b1;
            end else if (de_fell) begin
                since_de++;
            end
            if (hs_d && !hsync) begin
                if (de_fell) begin
                    assert (since_de == `H_FP) else flag_mismatch(T_TIMING, `H_FP, since_de);
                end
                de_fell = 1'b0;
                hs_len  = 0;
            end
            if (!hsync) begin
                hs_len++;
            end
            if (!hs_d && hsync) begin
                assert (hs_len == `H_SYNC) else flag_mismatch(T_TIMING, `H_SYNC, hs_len);
            end
            if (vs_d && !vsync) begin
                assert (active_lines == `V_ACTIVE)
                    else flag_mismatch(T_TIMING, `V_ACTIVE, active_lines);
                active_lines = 0;
                vs_len       = 0;
                vs_falls++;
            end
            if (!vsync) begin
                vs_len++;
            end
            if (!vs_d && vsync) begin
                assert (vs_len == `V_SYNC * `H_TOTAL)
                    else flag_mismatch(T_TIMING, `V_SYNC * `H_TOTAL, vs_len);
                vs_rises++;
            end
            de_d = pix_de;
            hs_d = hsync;
            vs_d = vsync;
        end
    end

    always @(posedge pix_clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout after %0d pixel clocks, the run did not finish", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // --------------------------------------------------------------------
    // test sequence
    // --------------------------------------------------------------------
    initial begin
        int base_errs;
        int failed;
        int total;
        pix_clk        = 1'b0;
        cam_pclk       = 1'b0;
        resetn         = 1'b0;
        cam_resetn     = 1'b0;
        burst_req      = 1'b0;
        cycles         = 0;
        seq_count      = 0;
        short_count    = 0;
        last_short_seq = 0;
        first_done     = 1'b0;
        de_len         = 0;
        hs_len         = 0;
        vs_len         = 0;
        since_de       = 0;
        active_lines   = 0;
        vs_falls       = 0;
        vs_rises       = 0;
        de_d           = 1'b0;
        hs_d           = 1'b1;
        vs_d           = 1'b1;
        de_fell        = 1'b0;
        shown_any      = 1'b0;
        resumed        = 1'b0;
        cur_tag        = 8'h00;
        cur_run        = 0;
        cur_seq        = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            errs[t] = 0;
        end
        repeat (16) @(posedge pix_clk);
        resetn <= 1'b1;
        @(posedge cam_pclk);
        cam_resetn <= 1'b1;

        while (!shown_any) @(posedge pix_clk);
        print_result(T_BLANK);
        while (vs_rises < 1) @(posedge pix_clk);
        print_result(T_TIMING);

        // burst lands in the blanking after the second vsync
        while (vs_falls < 2) @(posedge pix_clk);
        base_errs = errs[T_LINE] + errs[T_ORDER];
        burst_req <= 1'b1;
        while (!resumed && vs_falls < 3) @(posedge pix_clk);
        assert (resumed) else note_problem(T_EXHAUST, "display did not resume after the burst");
        while (vs_falls < 3) @(posedge pix_clk);
        assert (errs[T_LINE] + errs[T_ORDER] == base_errs)
            else note_problem(T_EXHAUST, "line checks failed after the burst");
        print_result(T_LINE);
        print_result(T_ORDER);
        print_result(T_EXHAUST);

        failed = 0;
        total  = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            total += errs[t];
            if (errs[t] != 0) begin
                failed++;
            end
        end
        $display("summary: %0d tests, %0d failed, %0d check failures", N_TESTS, failed, total);
        if (failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
